/* hw/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    ////////////////////////////////////////////////////////////
    // Register file sizes
    ////////////////////////////////////////////////////////////

    localparam int NUM_AREG   = 32;
    localparam int AREG_WIDTH = 5;
    localparam int PREG_WIDTH = 6;

    ////////////////////////////////////////////////////////////
    // Lane counts
    ////////////////////////////////////////////////////////////

    localparam int FETCH_WIDTH  = 2;
    localparam int COMMIT_WIDTH = 2;

    // Each rename lane looks up rs1, rs2 and the old rd mapping
    localparam int SRC_PORTS = 3 * FETCH_WIDTH;

    typedef logic [AREG_WIDTH-1:0] areg_t;
    typedef logic [PREG_WIDTH-1:0] preg_t;

endpackage

`default_nettype wire

/* hw/rat_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rat_port_if #(
    parameter int NREAD  = 1,
    parameter int NWRITE = 1
);

    // Read side, combinational lookup
    rename_pkg::areg_t [NREAD-1:0] vreg;
    rename_pkg::preg_t [NREAD-1:0] preg;

    // Write side, applied at the next rising edge
    logic              [NWRITE-1:0] we;
    rename_pkg::areg_t [NWRITE-1:0] waddr;
    rename_pkg::preg_t [NWRITE-1:0] wdata;

    modport bank (
        input  vreg,
        input  we,
        input  waddr,
        input  wdata,
        output preg
    );

    modport user (
        output vreg,
        output we,
        output waddr,
        output wdata,
        input  preg
    );

endinterface

`default_nettype wire

/* hw/rat_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module rat_bank #(
    parameter int NREAD  = 1,
    parameter int NWRITE = 1
) (
    input  logic           clk,
    input  logic           rst,
    rat_port_if.bank       port
);

    rename_pkg::preg_t map [rename_pkg::NUM_AREG];

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Reads see the map as it stood before this cycle's edge
    generate
        for (genvar r = 0; r < NREAD; r++) begin : g_read
            assign port.preg[r] = map[port.vreg[r]];
        end
    endgenerate

    ////////////////////////////////////////////////////////////
    // Write ports
    ////////////////////////////////////////////////////////////

    // Lanes are applied in ascending order so the highest lane wins
    // when several of them target the same entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::NUM_AREG; i++) begin
                map[i] <= rename_pkg::preg_t'(i);
            end
        end else begin
            for (int w = 0; w < NWRITE; w++) begin
                if (port.we[w]) begin
                    map[port.waddr[w]] <= port.wdata[w];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rename_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_ctrl (
    // Rename requests
    input  logic              [rename_pkg::FETCH_WIDTH-1:0]  rename_we,
    input  rename_pkg::areg_t [rename_pkg::FETCH_WIDTH-1:0]  rename_vrd,
    input  rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  rename_prd,
    input  rename_pkg::areg_t [rename_pkg::FETCH_WIDTH-1:0]  vrs1,
    input  rename_pkg::areg_t [rename_pkg::FETCH_WIDTH-1:0]  vrs2,
    input  rename_pkg::areg_t [rename_pkg::FETCH_WIDTH-1:0]  vrd,
    // Commit lanes
    input  logic              [rename_pkg::COMMIT_WIDTH-1:0] commit_en,
    input  logic              [rename_pkg::COMMIT_WIDTH-1:0] commit_we,
    input  rename_pkg::areg_t [rename_pkg::COMMIT_WIDTH-1:0] commit_vrd,
    input  rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0] commit_prd,
    // Recovery walk
    input  logic                                             walk,
    input  logic              [rename_pkg::COMMIT_WIDTH-1:0] walk_en,
    input  logic              [rename_pkg::COMMIT_WIDTH-1:0] walk_we,
    input  rename_pkg::areg_t [rename_pkg::COMMIT_WIDTH-1:0] walk_vrd,
    input  rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0] walk_old_prd,
    // Lookup results
    output rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  prs1,
    output rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  prs2,
    output rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  prd,
    output rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0] freed_prd,
    // Map banks
    rat_port_if.user                                         spec,
    rat_port_if.user                                         arch
);

    logic [rename_pkg::COMMIT_WIDTH-1:0] commit_wr;
    logic [rename_pkg::COMMIT_WIDTH-1:0] commit_cancel;

    ////////////////////////////////////////////////////////////
    // Speculative map
    ////////////////////////////////////////////////////////////

    // Read ports are laid out as rs1 group, rs2 group, then rd group
    generate
        for (genvar i = 0; i < rename_pkg::FETCH_WIDTH; i++) begin : g_spec
            assign spec.vreg[i]                               = vrs1[i];
            assign spec.vreg[rename_pkg::FETCH_WIDTH + i]     = vrs2[i];
            assign spec.vreg[2 * rename_pkg::FETCH_WIDTH + i] = vrd[i];

            assign prs1[i] = spec.preg[i];
            assign prs2[i] = spec.preg[rename_pkg::FETCH_WIDTH + i];
            assign prd[i]  = spec.preg[2 * rename_pkg::FETCH_WIDTH + i];

            // Walk lanes come youngest first, so the bank's lane priority
            // leaves the oldest mapping in place
            if (i < rename_pkg::COMMIT_WIDTH) begin : g_walk
                assign spec.we[i]    = walk ? (walk_en[i] & walk_we[i]) : rename_we[i];
                assign spec.waddr[i] = walk ? walk_vrd[i] : rename_vrd[i];
                assign spec.wdata[i] = walk ? walk_old_prd[i] : rename_prd[i];
            end else begin : g_no_walk
                assign spec.we[i]    = ~walk & rename_we[i];
                assign spec.waddr[i] = rename_vrd[i];
                assign spec.wdata[i] = rename_prd[i];
            end
        end
    endgenerate

    ////////////////////////////////////////////////////////////
    // Architectural map
    ////////////////////////////////////////////////////////////

    assign commit_wr = commit_en & commit_we;

    // A lane is dropped when a younger lane in the group writes the same register
    always_comb begin
        commit_cancel = '0;
        for (int i = 0; i < rename_pkg::COMMIT_WIDTH; i++) begin
            for (int j = i + 1; j < rename_pkg::COMMIT_WIDTH; j++) begin
                if (commit_wr[i] && commit_wr[j] && (commit_vrd[i] == commit_vrd[j])) begin
                    commit_cancel[i] = 1'b1;
                end
            end
        end
    end

    assign arch.vreg  = commit_vrd;
    assign arch.we    = commit_wr & ~commit_cancel;
    assign arch.waddr = commit_vrd;
    assign arch.wdata = commit_prd;

    // A cancelled lane's own register never becomes architectural
    generate
        for (genvar i = 0; i < rename_pkg::COMMIT_WIDTH; i++) begin : g_free
            assign freed_prd[i] = commit_cancel[i] ? commit_prd[i] : arch.preg[i];
        end
    endgenerate

endmodule

`default_nettype wire

/* hw/rename_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
    input  logic                                             clk,
    input  logic                                             rst,
    // Rename requests
    input  rename_pkg::areg_t [rename_pkg::FETCH_WIDTH-1:0]  vrs1,
    input  rename_pkg::areg_t [rename_pkg::FETCH_WIDTH-1:0]  vrs2,
    input  rename_pkg::areg_t [rename_pkg::FETCH_WIDTH-1:0]  vrd,
    input  logic              [rename_pkg::FETCH_WIDTH-1:0]  rename_we,
    input  rename_pkg::areg_t [rename_pkg::FETCH_WIDTH-1:0]  rename_vrd,
    input  rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  rename_prd,
    // Commit lanes
    input  logic              [rename_pkg::COMMIT_WIDTH-1:0] commit_en,
    input  logic              [rename_pkg::COMMIT_WIDTH-1:0] commit_we,
    input  rename_pkg::areg_t [rename_pkg::COMMIT_WIDTH-1:0] commit_vrd,
    input  rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0] commit_prd,
    // Recovery walk
    input  logic                                             walk,
    input  logic              [rename_pkg::COMMIT_WIDTH-1:0] walk_en,
    input  logic              [rename_pkg::COMMIT_WIDTH-1:0] walk_we,
    input  rename_pkg::areg_t [rename_pkg::COMMIT_WIDTH-1:0] walk_vrd,
    input  rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0] walk_old_prd,
    // Results
    output rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  prs1,
    output rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  prs2,
    output rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  prd,
    output rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0] freed_prd
);

    rat_port_if #(
        .NREAD  (rename_pkg::SRC_PORTS),
        .NWRITE (rename_pkg::FETCH_WIDTH)
    ) spec_port ();

    rat_port_if #(
        .NREAD  (rename_pkg::COMMIT_WIDTH),
        .NWRITE (rename_pkg::COMMIT_WIDTH)
    ) arch_port ();

    rename_ctrl ctrl0 (
        .rename_we    (rename_we),
        .rename_vrd   (rename_vrd),
        .rename_prd   (rename_prd),
        .vrs1         (vrs1),
        .vrs2         (vrs2),
        .vrd          (vrd),
        .commit_en    (commit_en),
        .commit_we    (commit_we),
        .commit_vrd   (commit_vrd),
        .commit_prd   (commit_prd),
        .walk         (walk),
        .walk_en      (walk_en),
        .walk_we      (walk_we),
        .walk_vrd     (walk_vrd),
        .walk_old_prd (walk_old_prd),
        .prs1         (prs1),
        .prs2         (prs2),
        .prd          (prd),
        .freed_prd    (freed_prd),
        .spec         (spec_port.user),
        .arch         (arch_port.user)
    );

    // Speculative map, read at rename and restored during walk
    rat_bank #(
        .NREAD  (rename_pkg::SRC_PORTS),
        .NWRITE (rename_pkg::FETCH_WIDTH)
    ) spec_bank (
        .clk  (clk),
        .rst  (rst),
        .port (spec_port.bank)
    );

    // Architectural map, written only at commit
    rat_bank #(
        .NREAD  (rename_pkg::COMMIT_WIDTH),
        .NWRITE (rename_pkg::COMMIT_WIDTH)
    ) arch_bank (
        .clk  (clk),
        .rst  (rst),
        .port (arch_port.bank)
    );

endmodule

`default_nettype wire

/* sim/rename_unit_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_unit_assert (
    input logic                                              clk,
    input logic                                              rst,
    input rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]   prs1,
    input rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]   prs2,
    input rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]   prd,
    input rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0]  freed_prd,
    input logic              [rename_pkg::COMMIT_WIDTH-1:0]  commit_en,
    input logic              [rename_pkg::COMMIT_WIDTH-1:0]  commit_we,
    input rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]   exp_prs1,
    input rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]   exp_prs2,
    input rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]   exp_prd,
    input rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0]  exp_freed
);

    int fail_count = 0;

    a_prs1: assert property (@(posedge clk) disable iff (rst) prs1 == exp_prs1)
        else begin
            fail_count++;
            $error("CHECK FAILED prs1 got %h expected %h", $sampled(prs1), $sampled(exp_prs1));
        end

    a_prs2: assert property (@(posedge clk) disable iff (rst) prs2 == exp_prs2)
        else begin
            fail_count++;
            $error("CHECK FAILED prs2 got %h expected %h", $sampled(prs2), $sampled(exp_prs2));
        end

    a_prd: assert property (@(posedge clk) disable iff (rst) prd == exp_prd)
        else begin
            fail_count++;
            $error("CHECK FAILED prd got %h expected %h", $sampled(prd), $sampled(exp_prd));
        end

    // Only lanes that really commit a write free a register
    for (genvar l = 0; l < rename_pkg::COMMIT_WIDTH; l++) begin : g_freed
        a_freed: assert property (@(posedge clk) disable iff (rst)
            (commit_en[l] && commit_we[l]) |-> (freed_prd[l] == exp_freed[l]))
            else begin
                fail_count++;
                $error("CHECK FAILED freed_prd[%0d] got %h expected %h", l,
                       $sampled(freed_prd[l]), $sampled(exp_freed[l]));
            end
    end

endmodule

`default_nettype wire

/* sim/tb_rename_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rename_unit;

    logic clk;
    logic rst;

    rename_pkg::areg_t [rename_pkg::FETCH_WIDTH-1:0]  vrs1;
    rename_pkg::areg_t [rename_pkg::FETCH_WIDTH-1:0]  vrs2;
    rename_pkg::areg_t [rename_pkg::FETCH_WIDTH-1:0]  vrd;
    logic              [rename_pkg::FETCH_WIDTH-1:0]  rename_we;
    rename_pkg::areg_t [rename_pkg::FETCH_WIDTH-1:0]  rename_vrd;
    rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  rename_prd;
    logic              [rename_pkg::COMMIT_WIDTH-1:0] commit_en;
    logic              [rename_pkg::COMMIT_WIDTH-1:0] commit_we;
    rename_pkg::areg_t [rename_pkg::COMMIT_WIDTH-1:0] commit_vrd;
    rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0] commit_prd;
    logic                                             walk;
    logic              [rename_pkg::COMMIT_WIDTH-1:0] walk_en;
    logic              [rename_pkg::COMMIT_WIDTH-1:0] walk_we;
    rename_pkg::areg_t [rename_pkg::COMMIT_WIDTH-1:0] walk_vrd;
    rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0] walk_old_prd;
    rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  prs1;
    rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  prs2;
    rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  prd;
    rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0] freed_prd;

    // Shadow maps and the values the checker expects this cycle
    rename_pkg::preg_t spec_model [rename_pkg::NUM_AREG];
    rename_pkg::preg_t arch_model [rename_pkg::NUM_AREG];
    rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  exp_prs1;
    rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  exp_prs2;
    rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]  exp_prd;
    rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0] exp_freed;

    rename_pkg::areg_t [rename_pkg::FETCH_WIDTH-1:0]  last_waddr;
    logic [15:0] lfsr;
    int          cycles = 0;
    int          cycle_limit = 2000;

    rename_unit dut0 (.*);

    bind rename_unit rename_unit_assert chk0 (
        .clk       (clk),
        .rst       (rst),
        .prs1      (prs1),
        .prs2      (prs2),
        .prd       (prd),
        .freed_prd (freed_prd),
        .commit_en (commit_en),
        .commit_we (commit_we),
        .exp_prs1  (tb_rename_unit.exp_prs1),
        .exp_prs2  (tb_rename_unit.exp_prs2),
        .exp_prd   (tb_rename_unit.exp_prd),
        .exp_freed (tb_rename_unit.exp_freed)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Later lanes are assigned last, so the highest lane wins here too
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::NUM_AREG; i++) begin
                spec_model[i] <= rename_pkg::preg_t'(i);
                arch_model[i] <= rename_pkg::preg_t'(i);
            end
        end else begin
            for (int l = 0; l < rename_pkg::FETCH_WIDTH; l++) begin
                if (!walk && rename_we[l]) spec_model[rename_vrd[l]] <= rename_prd[l];
            end
            for (int l = 0; l < rename_pkg::COMMIT_WIDTH; l++) begin
                if (walk && walk_en[l] && walk_we[l]) spec_model[walk_vrd[l]] <= walk_old_prd[l];
                if (commit_en[l] && commit_we[l]) arch_model[commit_vrd[l]] <= commit_prd[l];
            end
        end
    end

    always_comb begin
        for (int l = 0; l < rename_pkg::FETCH_WIDTH; l++) begin
            exp_prs1[l] = spec_model[vrs1[l]];
            exp_prs2[l] = spec_model[vrs2[l]];
            exp_prd[l]  = spec_model[vrd[l]];
        end
        // A lane overwritten by a younger lane frees its own register
        for (int l = 0; l < rename_pkg::COMMIT_WIDTH; l++) begin
            exp_freed[l] = arch_model[commit_vrd[l]];
            for (int j = l + 1; j < rename_pkg::COMMIT_WIDTH; j++) begin
                if (commit_en[l] && commit_we[l] && commit_en[j] && commit_we[j]
                        && (commit_vrd[l] == commit_vrd[j])) begin
                    exp_freed[l] = commit_prd[l];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int b = 0; b < n; b++) begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("test failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic read_sweep();
        for (int i = 0; i < rename_pkg::NUM_AREG; i++) begin
            @(posedge clk);
            #2;
            vrs1 = {rename_pkg::FETCH_WIDTH{rename_pkg::areg_t'(i)}};
            vrs2 = {rename_pkg::FETCH_WIDTH{rename_pkg::areg_t'(i)}};
            vrd  = {rename_pkg::FETCH_WIDTH{rename_pkg::areg_t'(i)}};
        end
    endtask

    task automatic drive_cycle(input bit do_rename, input bit do_commit, input bit do_walk);
        bit same_vrd;
        @(posedge clk);
        #2;
        same_vrd = (take_bits(2) == 0);
        for (int l = 0; l < rename_pkg::FETCH_WIDTH; l++) begin
            vrs1[l]       = rename_pkg::areg_t'(take_bits(5));
            vrs2[l]       = last_waddr[l];
            vrd[l]        = rename_pkg::areg_t'(take_bits(5));
            rename_we[l]  = do_rename && (take_bits(1) != 0);
            rename_vrd[l] = rename_pkg::areg_t'(take_bits(5));
            rename_prd[l] = rename_pkg::preg_t'(take_bits(6));
        end
        for (int l = 0; l < rename_pkg::COMMIT_WIDTH; l++) begin
            commit_en[l]    = do_commit && (take_bits(2) != 0);
            commit_we[l]    = (take_bits(2) != 0);
            commit_vrd[l]   = rename_pkg::areg_t'(take_bits(5));
            commit_prd[l]   = rename_pkg::preg_t'(take_bits(6));
            walk_en[l]      = (take_bits(2) != 0);
            walk_we[l]      = (take_bits(2) != 0);
            walk_vrd[l]     = rename_pkg::areg_t'(take_bits(5));
            walk_old_prd[l] = rename_pkg::preg_t'(take_bits(6));
        end
        walk = do_walk;
        if (same_vrd) begin
            rename_vrd[1] = rename_vrd[0];
            commit_vrd[1] = commit_vrd[0];
            walk_vrd[1]   = walk_vrd[0];
        end
        // Read this cycle's write targets now, and again through vrs2 next cycle
        last_waddr = do_walk ? walk_vrd : rename_vrd;
        vrs1[0]    = last_waddr[0];
        vrd[1]     = last_waddr[1];
    endtask

    initial begin
        lfsr         = 16'd18410;
        rst          = 1'b1;
        vrs1         = '0;
        vrs2         = '0;
        vrd          = '0;
        rename_we    = '0;
        rename_vrd   = '0;
        rename_prd   = '0;
        commit_en    = '0;
        commit_we    = '0;
        commit_vrd   = '0;
        commit_prd   = '0;
        walk         = 1'b0;
        walk_en      = '0;
        walk_we      = '0;
        walk_vrd     = '0;
        walk_old_prd = '0;
        last_waddr   = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        read_sweep();
        repeat (100) drive_cycle(1'b1, 1'b0, 1'b0);
        repeat (100) drive_cycle(1'b0, 1'b1, 1'b0);
        repeat (80) drive_cycle(1'b1, 1'b0, 1'b1);
        repeat (80) drive_cycle(1'b1, 1'b1, 1'b1);
        @(posedge clk);
        #5;
        if (dut0.chk0.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            stop_with_failure("the checker reported an error in the last cycle");
        end
    end

    always @(negedge clk) begin
        if (dut0.chk0.fail_count != 0) begin
            stop_with_failure("stopping at the first error from the checker");
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            stop_with_failure($sformatf("timeout: the run did not end within %0d cycles",
                                        cycle_limit));
        end
    end

endmodule

`default_nettype wire

/* flist.f */
hw/rename_pkg.sv
hw/rat_port_if.sv
hw/rat_bank.sv
hw/rename_ctrl.sv
hw/rename_unit.sv
sim/rename_unit_assert.sv
sim/tb_rename_unit.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         ?= tb_rename_unit
RTL_TOP     ?= rename_unit
FLIST       ?= flist.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 100
VFLAGS      ?= --timing --assert
SIM_ARGS    ?= +verilator+error+limit+$(ERROR_LIMIT)

SOURCES     := $(shell grep -v '^+' $(FLIST))
RTL_SOURCES := $(filter hw/%,$(SOURCES))
SIM_BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "test passed" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
